// File: stream_pkg.sv
package stream_pkg;

  // bits carried by one tkeep lane.
  localparam int BYTE_WIDTH = 8;

  // the adapter either collects narrow beats or walks a held wide word.
  typedef enum logic [1:0] {
    idle         = 2'd0, // waiting for the first beat of a word.
    transfer_in  = 2'd1, // packing narrow beats into the holding word.
    transfer_out = 2'd2  // presenting the held word or its next segment.
  } adapter_state_e;

endpackage

// File: mux_pkg.sv
package mux_pkg;

  typedef enum logic [1:0] {
    idle   = 2'd0, // no lane granted, arbitration happens here.
    pass_a = 2'd1, // lane a owns the output until its tlast.
    pass_b = 2'd2
  } mux_state_e;

  // tid value stamped on each output beat.
  typedef enum logic {
    src_a = 1'b0,
    src_b = 1'b1
  } src_e;

endpackage

// File: axis_width_adapter.sv
`timescale 1ns/1ps

module axis_width_adapter #(
  parameter int IN_WIDTH  = 8,
  parameter int OUT_WIDTH = 32
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [IN_WIDTH-1:0]                         in_tdata,
  input  logic [IN_WIDTH/stream_pkg::BYTE_WIDTH-1:0]  in_tkeep,
  input  logic                                        in_tvalid,
  output logic                                        in_tready,
  input  logic                                        in_tlast,
  input  logic                                        in_tuser,
  output logic [OUT_WIDTH-1:0]                        out_tdata,
  output logic [OUT_WIDTH/stream_pkg::BYTE_WIDTH-1:0] out_tkeep,
  output logic                                        out_tvalid,
  input  logic                                        out_tready,
  output logic                                        out_tlast,
  output logic                                        out_tuser
);

  localparam int IN_KEEP          = IN_WIDTH / stream_pkg::BYTE_WIDTH;
  localparam int OUT_KEEP         = OUT_WIDTH / stream_pkg::BYTE_WIDTH;
  localparam bit EXPAND_BUS       = OUT_KEEP > IN_KEEP;
  localparam int DATA_WIDTH       = EXPAND_BUS ? OUT_WIDTH : IN_WIDTH;
  localparam int KEEP_WIDTH       = EXPAND_BUS ? OUT_KEEP : IN_KEEP;
  localparam int CYCLE_COUNT      = EXPAND_BUS ? OUT_KEEP / IN_KEEP : IN_KEEP / OUT_KEEP;
  localparam int CYCLE_DATA_WIDTH = DATA_WIDTH / CYCLE_COUNT;
  localparam int CYCLE_KEEP_WIDTH = KEEP_WIDTH / CYCLE_COUNT;
  localparam int CNT_WIDTH        = $clog2(CYCLE_COUNT + 1);

  stream_pkg::adapter_state_e state, state_next;
  logic [CNT_WIDTH-1:0]        cnt, cnt_next;
  logic [DATA_WIDTH-1:0]       hold_tdata, hold_tdata_next;
  logic [KEEP_WIDTH-1:0]       hold_tkeep, hold_tkeep_next;
  logic                        hold_tlast, hold_tlast_next;
  logic                        hold_tuser, hold_tuser_next;
  logic [CYCLE_KEEP_WIDTH-1:0] seg_keep, seg_keep_after;
  logic                        last_cycle;
  logic                        in_tready_next;
  logic                        in_xfer;

  logic [OUT_WIDTH-1:0] int_tdata, skid_tdata;
  logic [OUT_KEEP-1:0]  int_tkeep, skid_tkeep;
  logic                 int_tvalid, int_tlast, int_tuser;
  logic                 skid_tvalid, skid_tlast, skid_tuser;
  logic                 int_tready, int_tready_early;

  assign in_xfer = in_tvalid && in_tready;

  always_comb begin
    state_next      = state;
    cnt_next        = cnt;
    hold_tdata_next = hold_tdata;
    hold_tkeep_next = hold_tkeep;
    hold_tlast_next = hold_tlast;
    hold_tuser_next = hold_tuser;
    seg_keep        = '0;
    seg_keep_after  = '0;
    last_cycle      = 1'b0;
    int_tdata       = '0;
    int_tkeep       = '0;
    int_tvalid      = 1'b0;
    int_tlast       = 1'b0;
    int_tuser       = 1'b0;
    in_tready_next  = 1'b0;
    case (state)
      stream_pkg::idle: begin
        in_tready_next = 1'b1;
        if (in_xfer) begin
          hold_tdata_next = DATA_WIDTH'(in_tdata);
          hold_tkeep_next = KEEP_WIDTH'(in_tkeep);
          hold_tlast_next = in_tlast;
          hold_tuser_next = in_tuser;
          if (EXPAND_BUS) begin
            cnt_next = CNT_WIDTH'(1);
            if (in_tlast) begin
              in_tready_next = 1'b0; // a one-beat frame is sent as a partial word.
              state_next = stream_pkg::transfer_out;
            end else begin
              state_next = stream_pkg::transfer_in;
            end
          end else begin
            // The low segment of a wide beat is offered straight away.
            seg_keep       = CYCLE_KEEP_WIDTH'(in_tkeep);
            seg_keep_after = CYCLE_KEEP_WIDTH'(in_tkeep >> CYCLE_KEEP_WIDTH);
            last_cycle     = (CYCLE_COUNT == 1) || (seg_keep != '1) ||
                             (seg_keep_after == '0);
            int_tdata  = OUT_WIDTH'(in_tdata);
            int_tkeep  = OUT_KEEP'(seg_keep);
            int_tvalid = 1'b1;
            int_tlast  = in_tlast && last_cycle;
            int_tuser  = in_tuser && last_cycle;
            cnt_next   = int_tready ? CNT_WIDTH'(1) : '0;
            if (!last_cycle || !int_tready) begin
              in_tready_next = 1'b0;
              state_next = stream_pkg::transfer_out;
            end
          end
        end
      end
      stream_pkg::transfer_in: begin
        in_tready_next = 1'b1;
        if (in_xfer) begin
          hold_tdata_next[cnt*CYCLE_DATA_WIDTH +: CYCLE_DATA_WIDTH] = CYCLE_DATA_WIDTH'(in_tdata);
          hold_tkeep_next[cnt*CYCLE_KEEP_WIDTH +: CYCLE_KEEP_WIDTH] = CYCLE_KEEP_WIDTH'(in_tkeep);
          hold_tlast_next = in_tlast;
          hold_tuser_next = in_tuser;
          cnt_next = cnt + 1'b1;
          if (cnt == CNT_WIDTH'(CYCLE_COUNT - 1) || in_tlast) begin
            in_tready_next = int_tready_early; // only take a new beat if the word can leave.
            state_next = stream_pkg::transfer_out;
          end
        end
      end
      stream_pkg::transfer_out: begin
        if (EXPAND_BUS) begin
          int_tdata  = OUT_WIDTH'(hold_tdata);
          int_tkeep  = OUT_KEEP'(hold_tkeep);
          int_tvalid = 1'b1;
          int_tlast  = hold_tlast;
          int_tuser  = hold_tuser;
          if (int_tready) begin
            if (in_xfer) begin
              hold_tdata_next = DATA_WIDTH'(in_tdata);
              hold_tkeep_next = KEEP_WIDTH'(in_tkeep);
              hold_tlast_next = in_tlast;
              hold_tuser_next = in_tuser;
              cnt_next        = CNT_WIDTH'(1);
              in_tready_next  = !in_tlast;
              state_next = in_tlast ? stream_pkg::transfer_out : stream_pkg::transfer_in;
            end else begin
              in_tready_next = 1'b1;
              state_next = stream_pkg::idle;
            end
          end
        end else begin
          seg_keep       = CYCLE_KEEP_WIDTH'(hold_tkeep >> (cnt * CYCLE_KEEP_WIDTH));
          seg_keep_after = CYCLE_KEEP_WIDTH'(hold_tkeep >> ((cnt + 1) * CYCLE_KEEP_WIDTH));
          last_cycle     = (cnt == CNT_WIDTH'(CYCLE_COUNT - 1)) || (seg_keep != '1) ||
                           (seg_keep_after == '0);
          int_tdata  = OUT_WIDTH'(hold_tdata >> (cnt * CYCLE_DATA_WIDTH));
          int_tkeep  = OUT_KEEP'(seg_keep);
          int_tvalid = 1'b1;
          int_tlast  = hold_tlast && last_cycle; // frame end only on the final segment.
          int_tuser  = hold_tuser && last_cycle;
          if (int_tready) begin
            cnt_next = cnt + 1'b1;
            if (last_cycle) begin
              in_tready_next = 1'b1;
              state_next = stream_pkg::idle;
            end
          end
        end
      end
      default: state_next = stream_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= stream_pkg::idle;
      cnt       <= '0;
      in_tready <= 1'b0;
    end else begin
      state     <= state_next;
      cnt       <= cnt_next;
      in_tready <= in_tready_next;
    end
  end

  always_ff @(posedge clk) begin
    hold_tdata <= hold_tdata_next;
    hold_tkeep <= hold_tkeep_next;
    hold_tlast <= hold_tlast_next;
    hold_tuser <= hold_tuser_next;
  end

  // Ready for the next cycle if the output drains or one of the two entries is free.
  assign int_tready_early = out_tready || (!skid_tvalid && (!out_tvalid || !int_tvalid));

  always_ff @(posedge clk) begin
    if (rst) begin
      int_tready  <= 1'b0;
      out_tvalid  <= 1'b0;
      skid_tvalid <= 1'b0;
    end else begin
      int_tready <= int_tready_early;
      if (int_tready) begin
        if (out_tready || !out_tvalid) begin
          out_tvalid <= int_tvalid;
        end else begin
          skid_tvalid <= int_tvalid;
        end
      end else if (out_tready) begin
        out_tvalid  <= skid_tvalid;
        skid_tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (int_tready) begin
      if (out_tready || !out_tvalid) begin
        out_tdata <= int_tdata;
        out_tkeep <= int_tkeep;
        out_tlast <= int_tlast;
        out_tuser <= int_tuser;
      end else begin
        skid_tdata <= int_tdata;
        skid_tkeep <= int_tkeep;
        skid_tlast <= int_tlast;
        skid_tuser <= int_tuser;
      end
    end else if (out_tready) begin
      out_tdata <= skid_tdata;
      out_tkeep <= skid_tkeep;
      out_tlast <= skid_tlast;
      out_tuser <= skid_tuser;
    end
  end

endmodule

// File: axis_frame_mux.sv
`timescale 1ns/1ps

module axis_frame_mux #(
  parameter int WIDTH = 32
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [WIDTH-1:0]                        a_tdata,
  input  logic [WIDTH/stream_pkg::BYTE_WIDTH-1:0] a_tkeep,
  input  logic                                    a_tvalid, a_tlast, a_tuser,
  output logic                                    a_tready,
  input  logic [WIDTH-1:0]                        b_tdata,
  input  logic [WIDTH/stream_pkg::BYTE_WIDTH-1:0] b_tkeep,
  input  logic                                    b_tvalid, b_tlast, b_tuser,
  output logic                                    b_tready,
  output logic [WIDTH-1:0]                        out_tdata,
  output logic [WIDTH/stream_pkg::BYTE_WIDTH-1:0] out_tkeep,
  output logic                                    out_tvalid, out_tlast, out_tuser,
  output mux_pkg::src_e                           out_tid,
  input  logic                                    out_tready
);

  localparam int KEEP_WIDTH = WIDTH / stream_pkg::BYTE_WIDTH;

  mux_pkg::mux_state_e   state, state_next;
  mux_pkg::src_e         grant, last_src, skid_tid;
  logic [WIDTH-1:0]      sel_tdata, skid_tdata;
  logic [KEEP_WIDTH-1:0] sel_tkeep, skid_tkeep;
  logic                  sel_tlast, sel_tuser, skid_tlast, skid_tuser, skid_tvalid;
  logic                  lane_ready, lane_ready_early;
  logic                  xfer;

  assign grant     = (state == mux_pkg::pass_b) ? mux_pkg::src_b : mux_pkg::src_a;
  assign a_tready  = lane_ready && (state == mux_pkg::pass_a);
  assign b_tready  = lane_ready && (state == mux_pkg::pass_b);
  assign xfer      = (a_tvalid && a_tready) || (b_tvalid && b_tready);
  assign sel_tdata = (grant == mux_pkg::src_b) ? b_tdata : a_tdata;
  assign sel_tkeep = (grant == mux_pkg::src_b) ? b_tkeep : a_tkeep;
  assign sel_tlast = (grant == mux_pkg::src_b) ? b_tlast : a_tlast;
  assign sel_tuser = (grant == mux_pkg::src_b) ? b_tuser : a_tuser;

  always_comb begin
    state_next = state;
    case (state)
      mux_pkg::idle: begin
        // the lane that did not send the previous frame wins a tie.
        if (a_tvalid && (!b_tvalid || last_src == mux_pkg::src_b)) begin
          state_next = mux_pkg::pass_a;
        end else if (b_tvalid) begin
          state_next = mux_pkg::pass_b;
        end
      end
      mux_pkg::pass_a, mux_pkg::pass_b: begin
        if (xfer && sel_tlast) state_next = mux_pkg::idle;
      end
      default: state_next = mux_pkg::idle;
    endcase
  end

  assign lane_ready_early = out_tready || (!skid_tvalid && (!out_tvalid || !xfer));

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= mux_pkg::idle;
      last_src    <= mux_pkg::src_b; // lane a gets the first tie.
      lane_ready  <= 1'b0;
      out_tvalid  <= 1'b0;
      skid_tvalid <= 1'b0;
    end else begin
      state      <= state_next;
      lane_ready <= lane_ready_early;
      if (xfer && sel_tlast) last_src <= grant;
      if (lane_ready) begin
        if (out_tready || !out_tvalid) begin
          out_tvalid <= xfer;
        end else begin
          skid_tvalid <= xfer;
        end
      end else if (out_tready) begin
        out_tvalid  <= skid_tvalid;
        skid_tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lane_ready) begin
      if (out_tready || !out_tvalid) begin
        out_tdata <= sel_tdata;
        out_tkeep <= sel_tkeep;
        out_tlast <= sel_tlast;
        out_tuser <= sel_tuser;
        out_tid   <= grant;
      end else begin
        skid_tdata <= sel_tdata;
        skid_tkeep <= sel_tkeep;
        skid_tlast <= sel_tlast;
        skid_tuser <= sel_tuser;
        skid_tid   <= grant;
      end
    end else if (out_tready) begin
      out_tdata <= skid_tdata;
      out_tkeep <= skid_tkeep;
      out_tlast <= skid_tlast;
      out_tuser <= skid_tuser;
      out_tid   <= skid_tid;
    end
  end

endmodule

// File: axis_merge_top.sv
`timescale 1ns/1ps

module axis_merge_top #(
  parameter int A_WIDTH   = 8,
  parameter int B_WIDTH   = 64,
  parameter int OUT_WIDTH = 32
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [A_WIDTH-1:0]                          a_tdata,
  input  logic [A_WIDTH/stream_pkg::BYTE_WIDTH-1:0]   a_tkeep,
  input  logic                                        a_tvalid, a_tlast, a_tuser,
  output logic                                        a_tready,
  input  logic [B_WIDTH-1:0]                          b_tdata,
  input  logic [B_WIDTH/stream_pkg::BYTE_WIDTH-1:0]   b_tkeep,
  input  logic                                        b_tvalid, b_tlast, b_tuser,
  output logic                                        b_tready,
  output logic [OUT_WIDTH-1:0]                        out_tdata,
  output logic [OUT_WIDTH/stream_pkg::BYTE_WIDTH-1:0] out_tkeep,
  output logic                                        out_tvalid, out_tlast, out_tuser,
  output mux_pkg::src_e                               out_tid,
  input  logic                                        out_tready
);

  localparam int OUT_KEEP = OUT_WIDTH / stream_pkg::BYTE_WIDTH;

  // both lanes reach the multiplexer at the common output width.
  logic [OUT_WIDTH-1:0] mux_a_tdata, mux_b_tdata;
  logic [OUT_KEEP-1:0]  mux_a_tkeep, mux_b_tkeep;
  logic                 mux_a_tvalid, mux_a_tready, mux_a_tlast, mux_a_tuser;
  logic                 mux_b_tvalid, mux_b_tready, mux_b_tlast, mux_b_tuser;

  axis_width_adapter #(.IN_WIDTH(A_WIDTH), .OUT_WIDTH(OUT_WIDTH)) adapter_a (
    .clk(clk), .rst(rst),
    .in_tdata(a_tdata), .in_tkeep(a_tkeep), .in_tvalid(a_tvalid), .in_tready(a_tready),
    .in_tlast(a_tlast), .in_tuser(a_tuser),
    .out_tdata(mux_a_tdata), .out_tkeep(mux_a_tkeep), .out_tvalid(mux_a_tvalid),
    .out_tready(mux_a_tready), .out_tlast(mux_a_tlast), .out_tuser(mux_a_tuser)
  );

  axis_width_adapter #(.IN_WIDTH(B_WIDTH), .OUT_WIDTH(OUT_WIDTH)) adapter_b (
    .clk(clk), .rst(rst),
    .in_tdata(b_tdata), .in_tkeep(b_tkeep), .in_tvalid(b_tvalid), .in_tready(b_tready),
    .in_tlast(b_tlast), .in_tuser(b_tuser),
    .out_tdata(mux_b_tdata), .out_tkeep(mux_b_tkeep), .out_tvalid(mux_b_tvalid),
    .out_tready(mux_b_tready), .out_tlast(mux_b_tlast), .out_tuser(mux_b_tuser)
  );

  axis_frame_mux #(.WIDTH(OUT_WIDTH)) mux_i (
    .clk(clk), .rst(rst),
    .a_tdata(mux_a_tdata), .a_tkeep(mux_a_tkeep), .a_tvalid(mux_a_tvalid),
    .a_tlast(mux_a_tlast), .a_tuser(mux_a_tuser), .a_tready(mux_a_tready),
    .b_tdata(mux_b_tdata), .b_tkeep(mux_b_tkeep), .b_tvalid(mux_b_tvalid),
    .b_tlast(mux_b_tlast), .b_tuser(mux_b_tuser), .b_tready(mux_b_tready),
    .out_tdata(out_tdata), .out_tkeep(out_tkeep), .out_tvalid(out_tvalid),
    .out_tlast(out_tlast), .out_tuser(out_tuser), .out_tid(out_tid),
    .out_tready(out_tready)
  );

endmodule

// File: tb_axis_merge.sv
`timescale 1ns/1ps

module tb_axis_merge;

  localparam int N_FRAMES = 10;

  logic          clk, rst;
  logic [7:0]    a_tdata;
  logic [0:0]    a_tkeep;
  logic          a_tvalid, a_tready, a_tlast, a_tuser;
  logic [63:0]   b_tdata;
  logic [7:0]    b_tkeep;
  logic          b_tvalid, b_tready, b_tlast, b_tuser;
  logic [31:0]   out_tdata;
  logic [3:0]    out_tkeep;
  logic          out_tvalid, out_tready, out_tlast, out_tuser;
  mux_pkg::src_e out_tid;

  logic [31:0]   frame_tbl [N_FRAMES]; // {source, length, first byte, tuser}.
  logic [9:0]    q_a[$], q_b[$];       // {tlast, tuser, byte} in output order.
  int            grant_q[$];           // 0 lane a, 1 lane b, 2 either lane.
  int            value_errors, protocol_errors, frames_seen, total_bytes;
  int            cycles, cycle_limit, prev_src;
  bit            arb_pending, in_frame;
  mux_pkg::src_e cur_tid;
  logic [31:0]   rand_state;

  axis_merge_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Fail at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
    value_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    protocol_errors++;
  endtask

  task automatic print_summary();
    $display("errors: %0d value mismatches, %0d protocol errors, %0d of %0d frames checked",
             value_errors, protocol_errors, frames_seen, N_FRAMES);
  endtask

  task automatic pop_expected(input mux_pkg::src_e src, output logic [9:0] e, output bit ok);
    ok = 1'b0;
    e  = '0;
    if (src == mux_pkg::src_a && q_a.size() != 0) begin
      e  = q_a.pop_front();
      ok = 1'b1;
    end else if (src == mux_pkg::src_b && q_b.size() != 0) begin
      e  = q_b.pop_front();
      ok = 1'b1;
    end
  endtask

  task automatic send_lane_a(input int idx);
    int i;
    int len;
    len = frame_tbl[idx][23:16];
    for (i = 0; i < len; i++) begin
      a_tdata  = frame_tbl[idx][15:8] + 8'(i);
      a_tkeep  = 1'b1;
      a_tvalid = 1'b1;
      a_tlast  = (i == len - 1);
      a_tuser  = a_tlast && frame_tbl[idx][0]; // tuser rides on the frame's last byte only.
      q_a.push_back({a_tlast, a_tuser, a_tdata});
      while (!a_tready) @(negedge clk);
      @(negedge clk);
    end
  endtask

  task automatic send_lane_b(input int idx);
    int base, j, len;
    logic [7:0] value;
    bit end_byte;
    len = frame_tbl[idx][23:16];
    for (base = 0; base < len; base += 8) begin
      b_tdata  = '0;
      b_tkeep  = '0;
      b_tvalid = 1'b1;
      b_tlast  = (base + 8 >= len);
      b_tuser  = b_tlast && frame_tbl[idx][0];
      for (j = 0; j < 8 && base + j < len; j++) begin
        value    = frame_tbl[idx][15:8] + 8'(base + j);
        end_byte = (base + j == len - 1);
        b_tdata[j*8 +: 8] = value;
        b_tkeep[j]        = 1'b1;
        q_b.push_back({end_byte, end_byte && b_tuser, value});
      end
      while (!b_tready) @(negedge clk);
      @(negedge clk);
    end
  endtask

  task automatic check_beat();
    logic [9:0] e;
    logic [3:0] exp_keep;
    bit ok, last_seen, starved;
    logic user_exp;
    int lane, k, exp_src;
    if (!in_frame) begin
      in_frame = 1'b1;
      cur_tid  = out_tid;
      if (grant_q.size() == 0) begin
        report_problem("a frame started on the output without a grant decision");
      end else begin
        exp_src = grant_q.pop_front();
        if (exp_src != 2 && exp_src != int'(out_tid)) report_mismatch("out_tid", exp_src, out_tid);
      end
    end else if (out_tid != cur_tid) begin
      report_mismatch("out_tid", cur_tid, out_tid); // frames must never interleave.
    end
    k = 0;
    last_seen = 1'b0;
    starved = 1'b0;
    user_exp = 1'b0;
    for (lane = 0; lane < 4; lane++) begin
      if (out_tkeep[lane] && !last_seen && !starved) begin
        pop_expected(out_tid, e, ok);
        if (!ok) begin
          report_problem("output byte arrived while its source expected nothing");
          starved = 1'b1;
        end else begin
          k++;
          if (out_tdata[lane*8 +: 8] !== e[7:0]) begin
            report_mismatch($sformatf("out_tdata[%0d]", lane), e[7:0], out_tdata[lane*8 +: 8]);
          end
          last_seen = e[9];
          user_exp  = e[8];
        end
      end
    end
    exp_keep = last_seen ? 4'(4'hf >> (4 - k)) : 4'hf;
    if (out_tkeep !== exp_keep) report_mismatch("out_tkeep", exp_keep, out_tkeep);
    if (out_tlast !== last_seen) report_mismatch("out_tlast", last_seen, out_tlast);
    if (out_tuser !== user_exp) report_mismatch("out_tuser", user_exp, out_tuser);
    if (out_tlast) begin
      in_frame = 1'b0;
      frames_seen++;
    end
  endtask

  task automatic watch_output();
    logic av, bv;
    while (frames_seen < N_FRAMES) begin
      @(negedge clk);
      rand_state = lcg_step(rand_state);
      out_tready = rand_state[31:24] < 8'd179; // about 70 percent ready.
      av = dut_i.mux_a_tvalid;
      bv = dut_i.mux_b_tvalid;
      // the multiplexer is idle here, so the next edge makes its choice.
      if (arb_pending && (av || bv)) begin
        if (av && bv) grant_q.push_back(prev_src < 0 ? 2 : 1 - prev_src);
        else grant_q.push_back(av ? 0 : 1);
        arb_pending = 1'b0;
      end
      if (av && dut_i.mux_a_tready && dut_i.mux_a_tlast) begin
        arb_pending = 1'b1;
        prev_src = 0;
      end
      if (bv && dut_i.mux_b_tready && dut_i.mux_b_tlast) begin
        arb_pending = 1'b1;
        prev_src = 1;
      end
      if (out_tvalid && out_tready) check_beat();
    end
  endtask

  initial begin
    while (cycle_limit == 0 || cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d frames seen", cycles, frames_seen,
             N_FRAMES);
    if (q_a.size() != 0) $display("lane a still waits for %0d bytes", q_a.size());
    if (q_b.size() != 0) $display("lane b still waits for %0d bytes", q_b.size());
    print_summary();
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst = 1'b1;
    {a_tdata, a_tkeep, a_tvalid, a_tlast, a_tuser} = '0;
    {b_tdata, b_tkeep, b_tvalid, b_tlast, b_tuser} = '0;
    out_tready = 1'b0;
    rand_state = 32'h482c;
    prev_src = -1;
    arb_pending = 1'b1;
    frame_tbl[0] = 32'h00_05_10_01;
    frame_tbl[1] = 32'h01_0b_40_00;
    frame_tbl[2] = 32'h00_01_80_00;
    frame_tbl[3] = 32'h01_17_20_01;
    frame_tbl[4] = 32'h00_08_90_01;
    frame_tbl[5] = 32'h01_01_a0_01;
    frame_tbl[6] = 32'h00_17_30_00;
    frame_tbl[7] = 32'h01_08_c0_00;
    frame_tbl[8] = 32'h00_04_70_01;
    frame_tbl[9] = 32'h01_10_f8_01; // byte values wrap past 8'hff.
    for (int i = 0; i < N_FRAMES; i++) total_bytes += frame_tbl[i][23:16];
    cycle_limit = 20 * total_bytes + 100;
    repeat (4) @(negedge clk);
    if (out_tvalid !== 1'b0) report_mismatch("out_tvalid", 0, out_tvalid);
    if (a_tready !== 1'b0) report_mismatch("a_tready", 0, a_tready);
    if (b_tready !== 1'b0) report_mismatch("b_tready", 0, b_tready);
    if (dut_i.adapter_a.state != stream_pkg::idle) report_problem("adapter a not idle in reset");
    if (dut_i.adapter_b.state != stream_pkg::idle) report_problem("adapter b not idle in reset");
    rst = 1'b0;
    @(negedge clk);
    if (a_tready !== 1'b1) report_mismatch("a_tready", 1, a_tready);
    if (b_tready !== 1'b1) report_mismatch("b_tready", 1, b_tready);
    fork
      begin
        for (int i = 0; i < N_FRAMES; i++) if (frame_tbl[i][24] == 1'b0) send_lane_a(i);
        a_tvalid = 1'b0;
      end
      begin
        for (int i = 0; i < N_FRAMES; i++) if (frame_tbl[i][24] == 1'b1) send_lane_b(i);
        b_tvalid = 1'b0;
      end
      watch_output();
    join
    if (q_a.size() != 0 || q_b.size() != 0) report_problem("bytes left over after the last frame");
    print_summary();
    if (value_errors + protocol_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verilog.f
stream_pkg.sv
mux_pkg.sv
axis_width_adapter.sv
axis_frame_mux.sv
axis_merge_top.sv
tb_axis_merge.sv

// File: Bender.yml
package:
  name: axis_merge

sources:
  - stream_pkg.sv
  - mux_pkg.sv
  - axis_width_adapter.sv
  - axis_frame_mux.sv
  - axis_merge_top.sv
  - target: simulation
    files:
      - tb_axis_merge.sv
